// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_read_datapath
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/oct_control.sv
// Turns on-die termination off whenever no read falls inside the termination window
`timescale 1ns/1ps
`default_nettype none

module oct_control (
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,
	input  read_datapath_pkg::afi_phase_t afi_rdata_en_full_i,
	output read_datapath_pkg::oct_t       force_oct_off_o
);

	import read_datapath_pkg::*;

	// History of the full read enable, bit j is the enable sampled j edges ago
	logic [OCT_OFF_DELAY-1:0] rdata_en_r;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r <= '0;
		end
		else
		begin
			rdata_en_r <= {rdata_en_r[OCT_OFF_DELAY-2:0], afi_rdata_en_full_i[0]};
		end
	end

	// Each DQS group has its own control flop so it can be placed
	// near that group's pins; all of them watch the same window
	for (genvar grp = 0; grp < AFI_DQS_WIDTH; grp++)
	begin : oct_group
		// Window covers reads issued OCT_ON_DELAY to OCT_OFF_DELAY cycles back
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				force_oct_off_o[grp] <= 1'b0;
			end
			else
			begin
				force_oct_off_o[grp] <= ~(|rdata_en_r[OCT_OFF_DELAY-1:OCT_ON_DELAY-1]);
			end
		end
	end

	// Groups must switch termination together or the bus sees mixed loading
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off_o == {AFI_DQS_WIDTH{force_oct_off_o[0]}})
	else
		$error("oct_control: force_oct_off bits differ (%b)", force_oct_off_o);

endmodule

`default_nettype wire

// File: rtl/read_datapath.sv
// Top of the DDR3 PHY read datapath with read valid, termination and data reordering
`timescale 1ns/1ps
`default_nettype none

module read_datapath (
	input  wire                               pll_afi_clk,
	input  wire                               reset_n_afi_clk,
	input  read_datapath_pkg::afi_phase_t     afi_rdata_en_i,
	input  read_datapath_pkg::afi_phase_t     afi_rdata_en_full_i,
	input  read_datapath_pkg::latency_count_t seq_read_latency_counter_i,
	input  read_datapath_pkg::afi_data_t      ddio_phy_dq_i,
	output read_datapath_pkg::afi_data_t      afi_rdata_o,
	output read_datapath_pkg::afi_data_t      phy_mux_read_fifo_q_o,
	output read_datapath_pkg::afi_phase_t     afi_rdata_valid_o,
	output read_datapath_pkg::oct_t           force_oct_off_o
);

	import read_datapath_pkg::*;

	// One bit per elapsed AFI cycle since the delayed read enable
	logic [MAX_READ_LATENCY-1:0] latency_shift;

	// **************************************************
	// Read valid path
	// **************************************************

	read_latency_shifter read_latency_shifter_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.latency_shift_o (latency_shift)
	);

	read_valid_select read_valid_select_inst (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.latency_shift_i            (latency_shift),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_valid_o          (afi_rdata_valid_o)
	);

	// Termination only depends on the full enable, so it runs beside the valid path
	oct_control oct_control_inst (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

	// **************************************************
	// Data reordering
	// **************************************************

	// The DDIO bus is ordered by DQS group, then by beat:
	//   G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
	// The AFI bus is ordered by beat, then by group:
	//   G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
	// The sequencer calibrates each group on its own and wants the
	// group-major order back, taken from afi_rdata
	for (genvar grp = 0; grp < MEM_READ_DQS_WIDTH; grp++)
	begin : map_group
		for (genvar slot = 0; slot < NUM_TIMESLOTS; slot++)
		begin : map_slot
			// Group-major offset of this nibble
			localparam int GROUP_OFS = DQ_GROUP_WIDTH * (NUM_TIMESLOTS * grp + slot);
			// Time-major offset of this nibble
			localparam int TIME_OFS = MEM_DQ_WIDTH * slot + DQ_GROUP_WIDTH * grp;

			assign afi_rdata_o[TIME_OFS +: DQ_GROUP_WIDTH] =
				ddio_phy_dq_i[GROUP_OFS +: DQ_GROUP_WIDTH];
			assign phy_mux_read_fifo_q_o[GROUP_OFS +: DQ_GROUP_WIDTH] =
				afi_rdata_o[TIME_OFS +: DQ_GROUP_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: rtl/read_datapath_pkg.sv
// Shared widths, latencies and bus types of the DDR3 PHY read datapath
`default_nettype none

package read_datapath_pkg;

	// **************************************************
	// Memory and AFI geometry
	// **************************************************

	// Eight DQ pins split into two read DQS groups of four bits
	localparam int MEM_DQ_WIDTH = 8;
	localparam int MEM_READ_DQS_WIDTH = 2;
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// Half rate AFI, so each AFI cycle carries two phases and four DDR beats
	localparam int AFI_RATE_RATIO = 2;
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;
	// One termination control bit per DQS group
	localparam int AFI_DQS_WIDTH = MEM_READ_DQS_WIDTH;

	// **************************************************
	// Latency settings
	// **************************************************

	// Depth of the read-latency shifter and width of the tap index into it
	localparam int MAX_READ_LATENCY = 32;
	localparam int LATENCY_COUNT_WIDTH = $clog2(MAX_READ_LATENCY);
	// Extra AFI cycles the read enable is held back before the shifter
	localparam int EXTRA_VFIFO_SHIFT = 1;

	// Read latency of the DRAM in memory clock cycles
	localparam int MEM_T_RL = 11;
	// Termination window edges in AFI cycles, derived from the read latency
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [AFI_RATE_RATIO-1:0] afi_phase_t;
	typedef logic [LATENCY_COUNT_WIDTH-1:0] latency_count_t;
	typedef logic [AFI_DQS_WIDTH-1:0] oct_t;

endpackage

`default_nettype wire

// File: rtl/read_latency_shifter.sv
// Delays the read enable by the extra shift and spreads it over a latency shift register
`timescale 1ns/1ps
`default_nettype none

module read_latency_shifter (
	input  wire                                            pll_afi_clk,
	input  wire                                            reset_n_afi_clk,
	input  read_datapath_pkg::afi_phase_t                  afi_rdata_en_i,
	output logic [read_datapath_pkg::MAX_READ_LATENCY-1:0] latency_shift_o
);

	import read_datapath_pkg::*;

	// **************************************************
	// Extra enable delay
	// **************************************************

	// The controller asserts both phases together in half rate,
	// so only phase 0 carries information into the valid path
	logic [EXTRA_VFIFO_SHIFT-1:0] extra_shift;
	logic                         rdata_en_delayed;

	// Each stage adds one AFI cycle between the read request and
	// the start of the latency count
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			extra_shift <= '0;
		end
		else
		begin
			for (int i = EXTRA_VFIFO_SHIFT - 1; i > 0; i--)
			begin
				extra_shift[i] <= extra_shift[i-1];
			end
			extra_shift[0] <= afi_rdata_en_i[0];
		end
	end

	// Oldest stage of the extra delay feeds the latency shifter
	assign rdata_en_delayed = extra_shift[EXTRA_VFIFO_SHIFT-1];

	// **************************************************
	// Read-latency shift register
	// **************************************************

	// Bit j holds the delayed enable j+1 cycles after it left the
	// extra stage, so the sequencer can pick any latency by tap index.
	// Nothing stalls here; every cycle shifts and many reads can be
	// in flight at once
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shift_o <= '0;
		end
		else
		begin
			latency_shift_o <= {latency_shift_o[MAX_READ_LATENCY-2:0], rdata_en_delayed};
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// An unknown enable would propagate into every tap and into the
	// valid output up to MAX_READ_LATENCY cycles later
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown(afi_rdata_en_i))
	else
		$error("read_latency_shifter: afi_rdata_en_i unknown (%b)", afi_rdata_en_i);

endmodule

`default_nettype wire

// File: rtl/read_valid_select.sv
// Picks the latency tap chosen by the sequencer and registers it onto afi_rdata_valid
`timescale 1ns/1ps
`default_nettype none

module read_valid_select (
	input  wire                                           pll_afi_clk,
	input  wire                                           reset_n_afi_clk,
	input  wire [read_datapath_pkg::MAX_READ_LATENCY-1:0] latency_shift_i,
	input  read_datapath_pkg::latency_count_t             seq_read_latency_counter_i,
	output read_datapath_pkg::afi_phase_t                 afi_rdata_valid_o
);

	import read_datapath_pkg::*;

	// Registered tap of the latency shifter
	logic read_valid_sel;

	// The count spans the whole shifter, so every value is a legal tap.
	// The output register doubles as the keeper that timing scripts
	// use to locate the AFI clock, so it stays a plain flop
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_valid_sel <= 1'b0;
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			read_valid_sel <= latency_shift_i[seq_read_latency_counter_i];
			// Both half-rate phases carry the same valid in this mode
			afi_rdata_valid_o <= {AFI_RATE_RATIO{read_valid_sel}};
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// An unknown count selects an unknown tap two cycles later
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown(seq_read_latency_counter_i))
	else
		$error("read_valid_select: latency count unknown (%h)", seq_read_latency_counter_i);

	// The controller expects whole AFI cycles of data, never a single phase
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o == {AFI_RATE_RATIO{afi_rdata_valid_o[0]}})
	else
		$error("read_valid_select: valid phases differ (%b)", afi_rdata_valid_o);

endmodule

`default_nettype wire

// File: sim.f
rtl/read_datapath_pkg.sv
rtl/read_latency_shifter.sv
rtl/read_valid_select.sv
rtl/oct_control.sv
rtl/read_datapath.sv
tests/afi_clock_gen.sv
tests/tb_read_datapath.sv

// File: tests/afi_clock_gen.sv
// Clock and power-on reset source for the read datapath testbench
`timescale 1ns/1ps
`default_nettype none

module afi_clock_gen (
	output logic pll_afi_clk_o,
	output logic reset_n_afi_clk_o
);

	// 100 ns AFI period, starting high so time zero brings no falling edge
	initial
	begin
		pll_afi_clk_o = 1'b1;
		forever
		begin
			#50 pll_afi_clk_o = ~pll_afi_clk_o;
		end
	end

	// Ten cycles of reset, released a quarter period after a rising edge
	// so the next falling edge sees it high before any edge clocks it
	initial
	begin
		reset_n_afi_clk_o = 1'b0;
		repeat (10) @(negedge pll_afi_clk_o);
		@(posedge pll_afi_clk_o);
		#25 reset_n_afi_clk_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/tb_read_datapath.sv
// Testbench for the read datapath with an enable history and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_read_datapath;

	import read_datapath_pkg::*;

	logic           pll_afi_clk;
	logic           reset_n_afi_clk;
	afi_phase_t     afi_rdata_en_i;
	afi_phase_t     afi_rdata_en_full_i;
	latency_count_t seq_read_latency_counter_i;
	afi_data_t      ddio_phy_dq_i;
	afi_data_t      afi_rdata_o;
	afi_data_t      phy_mux_read_fifo_q_o;
	afi_phase_t     afi_rdata_valid_o;
	oct_t           force_oct_off_o;

	integer seed;
	int reset_errors = 0;
	int valid_errors = 0;
	int oct_errors = 0;
	int data_errors = 0;
	int timeouts = 0;

	// Sampled enables, bit k holds the enable taken k edges before the latest one
	logic [MAX_READ_LATENCY+2:0] en_hist;
	logic [OCT_OFF_DELAY:0]      full_hist;
	latency_count_t              lat_prev;
	logic [7:0]                  lat_steady;
	logic                        first_edge_done;
	logic [5:0]                  valid_tap;
	afi_phase_t                  valid_expected;
	oct_t                        oct_expected;
	afi_data_t                   rdata_expected;

	afi_clock_gen afi_clock_gen_inst (
		.pll_afi_clk_o     (pll_afi_clk),
		.reset_n_afi_clk_o (reset_n_afi_clk)
	);

	read_datapath read_datapath_inst (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.afi_rdata_o                (afi_rdata_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	// **************************************************
	// Reference model
	// **************************************************

	// Moves beat t of group g from offset 16g+4t to offset 8t+4g
	function automatic afi_data_t time_major(input afi_data_t dq);
		afi_data_t                 result;
		logic [DQ_GROUP_WIDTH-1:0] nibble;
		result = '0;
		for (int t = 0; t < NUM_TIMESLOTS; t++)
		begin
			for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
			begin
				nibble = DQ_GROUP_WIDTH'(dq >> (DQ_GROUP_WIDTH * NUM_TIMESLOTS * g + DQ_GROUP_WIDTH * t));
				result = result | (afi_data_t'(nibble) << (MEM_DQ_WIDTH * t + DQ_GROUP_WIDTH * g));
			end
		end
		return result;
	endfunction

	// The history clears with the DUT so both start from an idle bus
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist <= '0;
			full_hist <= '0;
			lat_prev <= '0;
			lat_steady <= '0;
			first_edge_done <= 1'b0;
		end
		else
		begin
			en_hist <= {en_hist[MAX_READ_LATENCY+1:0], afi_rdata_en_i[0]};
			full_hist <= {full_hist[OCT_OFF_DELAY-1:0], afi_rdata_en_full_i[0]};
			lat_prev <= seq_read_latency_counter_i;
			first_edge_done <= 1'b1;
			// Edges seen since the latency count last moved, saturating
			if (seq_read_latency_counter_i != lat_prev)
				lat_steady <= '0;
			else if (lat_steady < 8'd200)
				lat_steady <= lat_steady + 8'd1;
		end
	end

	always_comb
	begin
		// Extra shift stage, tap register and output register add three edges
		valid_tap = {1'b0, lat_prev} + 6'd3;
		valid_expected = {AFI_RATE_RATIO{en_hist[valid_tap]}};
		// Termination stays on while any read of 3 to 8 edges back is pending
		oct_expected = {AFI_DQS_WIDTH{~|full_hist[OCT_OFF_DELAY:OCT_ON_DELAY]}};
		rdata_expected = time_major(ddio_phy_dq_i);
	end

	// **************************************************
	// Checks, sampled mid-cycle on the falling edge
	// **************************************************

	assert property (@(negedge pll_afi_clk) (!reset_n_afi_clk || !first_edge_done) |->
		(afi_rdata_valid_o == '0 && force_oct_off_o == '0))
	else
	begin
		reset_errors++;
		$display("CHECK FAILED afi_rdata_valid_o=%h force_oct_off_o=%h, both expected 0 at reset",
			afi_rdata_valid_o, force_oct_off_o);
	end

	// Only once the count has held long enough to flush the old tap
	assert property (@(negedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(first_edge_done && seq_read_latency_counter_i == lat_prev &&
		lat_steady > {2'b0, valid_tap}) |-> afi_rdata_valid_o == valid_expected)
	else
	begin
		valid_errors++;
		$display("CHECK FAILED afi_rdata_valid_o: got %h, expected %h (latency %h)",
			afi_rdata_valid_o, valid_expected, lat_prev);
	end

	assert property (@(negedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		first_edge_done |-> force_oct_off_o == oct_expected)
	else
	begin
		oct_errors++;
		$display("CHECK FAILED force_oct_off_o: got %h, expected %h",
			force_oct_off_o, oct_expected);
	end

	assert property (@(negedge pll_afi_clk) afi_rdata_o == rdata_expected)
	else
	begin
		data_errors++;
		$display("CHECK FAILED afi_rdata_o: got %h, expected %h", afi_rdata_o, rdata_expected);
	end

	assert property (@(negedge pll_afi_clk) phy_mux_read_fifo_q_o == ddio_phy_dq_i)
	else
	begin
		data_errors++;
		$display("CHECK FAILED phy_mux_read_fifo_q_o: got %h, expected %h",
			phy_mux_read_fifo_q_o, ddio_phy_dq_i);
	end

	// **************************************************
	// Stimulus
	// **************************************************

	// One AFI cycle with both enables on both phases and fresh DDIO data
	task automatic drive_cycle(input logic en, input logic full);
		logic [31:0] data;
		@(posedge pll_afi_clk);
		data = $random(seed);
		afi_rdata_en_i <= {AFI_RATE_RATIO{en}};
		afi_rdata_en_full_i <= {AFI_RATE_RATIO{full}};
		ddio_phy_dq_i <= data;
	endtask

	task automatic idle_cycles(input int count);
		for (int i = 0; i < count; i++)
		begin
			drive_cycle(1'b0, 1'b0);
		end
	endtask

	task automatic wait_reset_release(input int limit);
		int cycles;
		cycles = 0;
		while (!reset_n_afi_clk && cycles < limit)
		begin
			@(negedge pll_afi_clk);
			cycles++;
		end
		if (!reset_n_afi_clk)
		begin
			timeouts++;
			$display("Timeout: reset was still asserted after %0d cycles", limit);
		end
	endtask

	// Waits until no read is in flight and the valid output is back low
	task automatic wait_valid_drain(input int limit);
		int cycles;
		cycles = 0;
		while ((en_hist != '0 || afi_rdata_valid_o != '0) && cycles < limit)
		begin
			@(negedge pll_afi_clk);
			cycles++;
		end
		if (en_hist != '0 || afi_rdata_valid_o != '0)
		begin
			timeouts++;
			$display("Timeout: afi_rdata_valid_o did not settle low within %0d cycles", limit);
		end
	endtask

	// Random bursts at one latency, with quiet cycles around the count change
	task automatic run_valid_bursts(input latency_count_t latency);
		logic [3:0]  burst_left;
		logic [31:0] pick;
		burst_left = '0;
		@(posedge pll_afi_clk);
		seq_read_latency_counter_i <= latency;
		idle_cycles(40);
		for (int i = 0; i < 80; i++)
		begin
			pick = $random(seed);
			// Start a burst of one to eight reads about once in four idle cycles
			if (burst_left == 4'd0 && pick[1:0] == 2'd0)
				burst_left = {1'b0, pick[4:2]} + 4'd1;
			drive_cycle(burst_left != 4'd0, burst_left != 4'd0);
			if (burst_left != 4'd0)
				burst_left = burst_left - 4'd1;
		end
		idle_cycles(40);
		wait_valid_drain(64);
	endtask

	task automatic run_oct_pulses();
		logic [31:0] pick;
		// Sparse pulses, mostly further apart than the window is wide
		for (int i = 0; i < 120; i++)
		begin
			pick = $random(seed);
			drive_cycle(1'b0, pick[3:0] == 4'd0);
		end
		// Dense traffic with long back-to-back runs
		for (int i = 0; i < 120; i++)
		begin
			pick = $random(seed);
			drive_cycle(1'b0, pick[2:0] != 3'd0);
		end
		idle_cycles(20);
	endtask

	initial
	begin
		seed = 32'h163a;
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		seq_read_latency_counter_i = '0;
		ddio_phy_dq_i = '0;
		wait_reset_release(40);
		idle_cycles(40);
		run_valid_bursts(5'd0);
		run_valid_bursts(5'd5);
		run_valid_bursts(5'd31);
		run_oct_pulses();
		$display("Error counts: reset %0d, valid %0d, oct %0d, data %0d, timeout %0d",
			reset_errors, valid_errors, oct_errors, data_errors, timeouts);
		if (reset_errors + valid_errors + oct_errors + data_errors + timeouts == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
